// ==== sim.f ====
+incdir+bench
design/kvs_ctrl_pkg.sv
design/kvs_mem_pkg.sv
design/kvs_ctrl_regs.sv
design/kvs_run_timer.sv
design/mem_cmd_router.sv
design/mem_chan_xlate.sv
design/kvs_kernel_top.sv
bench/kvs_kernel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := kvs_kernel_tb
FILELIST  := sim.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard bench/*.svh)
PASS_MSG  := TESTBENCH PASSED

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/kvs_kernel_model.svh ====
`ifndef KVS_KERNEL_MODEL_SVH
`define KVS_KERNEL_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// reference model of the control layer
//////////////////////////////////////////////////////////////////////

// host command expected at the memory ports
typedef struct {
  int                      due;  // cycle it shows at the memory side
  int                      chan;
  logic                    write;
  logic [HOST_ADDR_W-1:0]  addr;
  logic [BURST_LEN_W-1:0]  len;
} exp_cmd_t;

exp_cmd_t                exp_q[$];  // all channels, in issue order
logic [HOST_ADDR_W-1:0]  base_exp [N_CHAN] = '{default: '0};
logic [RUN_CNT_W-1:0]    run_len = '0;
logic                    start_level = 1'b0;
logic                    done_sticky = 1'b0;
int                      start_cyc = -1000;  // no start seen yet
int                      start_len = 0;
int                      reject_total = 0;
int                      issue_total [N_CHAN] = '{default: 0};

// word 0 base low, 1 base high, 2 issue count
function automatic logic [REG_ADDR_W-1:0] chan_reg_addr(input int ch, input int word);
  return ADDR_CHAN_BASE + REG_ADDR_W'(CHAN_STRIDE * ch + 4 * word);
endfunction

// busy from two cycles after the start write, for run length cycles
function automatic logic exp_idle(input int k);
  return !(k >= start_cyc + 2 && k < start_cyc + 2 + start_len);
endfunction

function automatic logic exp_done(input int k);
  return k == start_cyc + 2 + start_len;  // first idle cycle after the run
endfunction

function automatic void model_reg_write(input logic [REG_ADDR_W-1:0] addr,
                                        input logic [REG_DATA_W-1:0] data);
  case (addr)
    ADDR_CTRL: begin
      if (data[0] && !start_level) begin  // rising start bit
        start_cyc = cyc;
        start_len = int'(run_len[31:0]);
      end
      start_level = data[0];
      done_sticky = 1'b0;
    end
    ADDR_RUN_LO: run_len[31:0]  = data;
    ADDR_RUN_HI: run_len[63:32] = data;
    default: ;
  endcase
  for (int ch = 0; ch < N_CHAN; ch++) begin
    if (addr == chan_reg_addr(ch, 0))
      base_exp[ch][31:0] = data;
    if (addr == chan_reg_addr(ch, 1))
      base_exp[ch][63:32] = data;
  end
endfunction

function automatic void model_cmd(input logic write, input int chan,
                                  input logic [LOCAL_ADDR_W-1:0] addr,
                                  input logic [BURST_LEN_W-1:0] len, input logic idle_now);
  exp_cmd_t e;
  if (idle_now || chan >= N_CHAN) begin
    reject_total++;
  end else begin
    e.due   = cyc + 2;
    e.chan  = chan;
    e.write = write;
    e.addr  = base_exp[chan] + HOST_ADDR_W'(addr);
    e.len   = len;
    exp_q.push_back(e);
    issue_total[chan]++;
  end
endfunction

function automatic logic [REG_DATA_W-1:0] exp_reg_value(input logic [REG_ADDR_W-1:0] addr);
  logic [REG_DATA_W-1:0] v;
  v = '0;  // unmapped
  case (addr)
    ADDR_CTRL:   v[0]   = start_level;
    ADDR_STATUS: v[1:0] = {done_sticky, exp_idle(cyc)};
    ADDR_RUN_LO: v      = run_len[31:0];
    ADDR_RUN_HI: v      = run_len[63:32];
    ADDR_REJECT: v      = REG_DATA_W'(reject_total);
    default: ;
  endcase
  for (int ch = 0; ch < N_CHAN; ch++) begin
    if (addr == chan_reg_addr(ch, 0))
      v = base_exp[ch][31:0];
    if (addr == chan_reg_addr(ch, 1))
      v = base_exp[ch][63:32];
    if (addr == chan_reg_addr(ch, 2))
      v = REG_DATA_W'(issue_total[ch]);
  end
  return v;
endfunction

`endif

// ==== bench/kvs_kernel_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module kvs_kernel_tb;
  import kvs_ctrl_pkg::*;
  import kvs_mem_pkg::*;

  localparam int N_CHAN = 2;

  // phase lengths in cycles, the watchdog allows twice their sum
  localparam int PH_RESET    = 10;
  localparam int PH_REGS     = 50;
  localparam int PH_RUNS     = 110;
  localparam int PH_TRAFFIC  = 260;
  localparam int TIMEOUT_CYC = 2 * (PH_RESET + PH_REGS + PH_RUNS + PH_TRAFFIC);

  logic                              ap_clk = 1'b0;
  logic                              ap_rst_n;
  logic                              reg_wr;
  logic                              reg_rd;
  logic [REG_ADDR_W-1:0]             reg_addr;
  logic [REG_DATA_W-1:0]             reg_wdata;
  logic                              reg_rvalid;
  logic [REG_DATA_W-1:0]             reg_rdata;
  logic                              cmd_valid;
  logic                              cmd_write;
  logic [CHAN_ID_W-1:0]              cmd_chan;
  logic [LOCAL_ADDR_W-1:0]           cmd_addr;
  logic [BURST_LEN_W-1:0]            cmd_len;
  logic                              idle;
  logic                              done;
  logic [N_CHAN-1:0]                 mem_valid;
  logic [N_CHAN-1:0]                 mem_write;
  logic [N_CHAN*HOST_ADDR_W-1:0]     mem_addr;
  logic [N_CHAN*BURST_LEN_W-1:0]     mem_len;

  int cyc    = 0;
  int checks = 0;
  int errors = 0;

  `include "kvs_kernel_model.svh"

  kvs_kernel_top #(.N_CHAN(N_CHAN)) kvs_kernel_top_i (
    .ap_clk, .ap_rst_n, .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rvalid, .reg_rdata,
    .cmd_valid, .cmd_write, .cmd_chan, .cmd_addr, .cmd_len, .idle, .done,
    .mem_valid, .mem_write, .mem_addr, .mem_len
  );

  always #50 ap_clk = ~ap_clk;

  always @(posedge ap_clk) cyc <= cyc + 1;

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // register port and engine stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] data);
    @(posedge ap_clk);
    #1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    model_reg_write(addr, data);
    @(posedge ap_clk);
    #1;
    reg_wr = 1'b0;
  endtask

  task automatic check_reg(input logic [REG_ADDR_W-1:0] addr);
    logic [REG_DATA_W-1:0] exp;
    @(posedge ap_clk);
    #1;
    reg_rd   = 1'b1;
    reg_addr = addr;
    exp      = exp_reg_value(addr);
    @(posedge ap_clk);
    #1;
    reg_rd = 1'b0;  // answer is due now
    expect_eq("reg_rvalid", 64'd1, 64'(reg_rvalid));
    expect_eq($sformatf("reg_rdata[%02h]", addr), 64'(exp), 64'(reg_rdata));
  endtask

  task automatic start_run(input logic [REG_DATA_W-1:0] len);
    reg_write(ADDR_RUN_LO, len);
    reg_write(ADDR_RUN_HI, '0);
    reg_write(ADDR_CTRL, 32'd0);  // start needs a fresh rising edge
    reg_write(ADDR_CTRL, 32'd1);
  endtask

  task automatic wait_done();
    @(posedge ap_clk);
    #1;
    while (done !== 1'b1) begin
      @(posedge ap_clk);
      #1;
    end
  endtask

  task automatic wait_busy();
    while (idle !== 1'b0) begin
      @(posedge ap_clk);
      #1;
    end
  endtask

  // bad_pct percent of commands name a channel that does not exist
  task automatic send_cmds(input int n, input int bad_pct);
    for (int i = 0; i < n; i++) begin
      @(posedge ap_clk);
      #1;
      cmd_valid = ($urandom_range(99) < 80);
      cmd_write = 1'($urandom_range(1));
      if ($urandom_range(99) < bad_pct)
        cmd_chan = CHAN_ID_W'($urandom_range(15, N_CHAN));
      else
        cmd_chan = CHAN_ID_W'($urandom_range(N_CHAN - 1));
      cmd_addr = LOCAL_ADDR_W'({$urandom, $urandom});
      cmd_len  = BURST_LEN_W'($urandom);
      if (cmd_valid)
        model_cmd(cmd_write, int'(cmd_chan), cmd_addr, cmd_len, idle);
    end
    @(posedge ap_clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor, stable at the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge ap_clk) begin : out_monitor
    exp_cmd_t e;
    logic     hit;
    if (ap_rst_n) begin
      hit = 1'b0;
      if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
        e   = exp_q.pop_front();
        hit = 1'b1;
      end
      expect_eq("idle", 64'(exp_idle(cyc)), 64'(idle));
      expect_eq("done", 64'(exp_done(cyc)), 64'(done));
      if (exp_done(cyc))
        done_sticky = 1'b1;  // visible to reads from the next cycle
      for (int ch = 0; ch < N_CHAN; ch++) begin
        expect_eq($sformatf("mem_valid[%0d]", ch), 64'(hit && e.chan == ch),
                  64'(mem_valid[ch]));
        if (hit && e.chan == ch) begin
          expect_eq($sformatf("mem_write[%0d]", ch), 64'(e.write), 64'(mem_write[ch]));
          expect_eq($sformatf("mem_addr[%0d]", ch), e.addr,
                    mem_addr[ch*HOST_ADDR_W +: HOST_ADDR_W]);
          expect_eq($sformatf("mem_len[%0d]", ch), 64'(e.len),
                    64'(mem_len[ch*BURST_LEN_W +: BURST_LEN_W]));
        end
      end
    end
  end

  initial begin : watchdog
    while (cyc < TIMEOUT_CYC)
      @(posedge ap_clk);
    $display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYC);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main_seq
    ap_rst_n  = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    cmd_valid = 1'b0;
    cmd_write = 1'b0;
    cmd_chan  = '0;
    cmd_addr  = '0;
    cmd_len   = '0;
    void'($urandom(55));
    repeat (8) @(posedge ap_clk);
    #1;
    ap_rst_n = 1'b1;

    // reset state and register readback
    expect_eq("idle", 64'd1, 64'(idle));
    expect_eq("done", 64'd0, 64'(done));
    expect_eq("mem_valid", 64'd0, 64'(mem_valid));
    check_reg(ADDR_STATUS);
    for (int ch = 0; ch < N_CHAN; ch++) begin
      reg_write(chan_reg_addr(ch, 0), $urandom);
      reg_write(chan_reg_addr(ch, 1), $urandom);
    end
    reg_write(ADDR_RUN_LO, $urandom);
    reg_write(ADDR_RUN_HI, $urandom);
    check_reg(ADDR_RUN_LO);
    check_reg(ADDR_RUN_HI);
    for (int ch = 0; ch < N_CHAN; ch++)
      for (int w = 0; w < 3; w++)
        check_reg(chan_reg_addr(ch, w));
    check_reg(8'h14);
    check_reg(8'h2C);  // hole inside channel 0 block
    check_reg(8'hF0);

    // run timing, then a zero length run
    start_run($urandom_range(40, 5));
    wait_done();
    check_reg(ADDR_STATUS);
    start_run(32'd0);
    wait_done();
    check_reg(ADDR_STATUS);

    // traffic while idle, then during a run shorter than the burst
    send_cmds(20, 30);
    start_run(32'd150);
    wait_busy();
    send_cmds(200, 25);
    repeat (4) @(posedge ap_clk);
    check_reg(ADDR_REJECT);
    for (int ch = 0; ch < N_CHAN; ch++)
      check_reg(chan_reg_addr(ch, 2));

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/kvs_kernel_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module kvs_kernel_top #(
  parameter int N_CHAN = 2
) (
  input  wire                                            ap_clk,
  input  wire                                            ap_rst_n,
  // register port
  input  wire                                            reg_wr,
  input  wire                                            reg_rd,
  input  wire [kvs_ctrl_pkg::REG_ADDR_W-1:0]             reg_addr,
  input  wire [kvs_ctrl_pkg::REG_DATA_W-1:0]             reg_wdata,
  output logic                                           reg_rvalid,
  output logic [kvs_ctrl_pkg::REG_DATA_W-1:0]            reg_rdata,
  // engine commands
  input  wire                                            cmd_valid,
  input  wire                                            cmd_write,
  input  wire [kvs_mem_pkg::CHAN_ID_W-1:0]               cmd_chan,
  input  wire [kvs_mem_pkg::LOCAL_ADDR_W-1:0]            cmd_addr,
  input  wire [kvs_mem_pkg::BURST_LEN_W-1:0]             cmd_len,
  output logic                                           idle,
  output logic                                           done,
  // memory channels, channel i in slice i
  output logic [N_CHAN-1:0]                              mem_valid,
  output logic [N_CHAN-1:0]                              mem_write,
  output logic [N_CHAN*kvs_mem_pkg::HOST_ADDR_W-1:0]     mem_addr,
  output logic [N_CHAN*kvs_mem_pkg::BURST_LEN_W-1:0]     mem_len
);
  import kvs_ctrl_pkg::*;
  import kvs_mem_pkg::*;

  logic                                start_bit;
  logic [RUN_CNT_W-1:0]                run_cycles;
  logic [N_CHAN-1:0][HOST_ADDR_W-1:0]  chan_base;
  logic [N_CHAN-1:0][CNT_W-1:0]        issue_count;
  logic [CNT_W-1:0]                    reject_count;
  logic [N_CHAN-1:0]                   chan_valid;
  logic                                chan_write;
  logic [LOCAL_ADDR_W-1:0]             chan_addr;
  logic [BURST_LEN_W-1:0]              chan_len;

  kvs_ctrl_regs #(.N_CHAN(N_CHAN)) kvs_ctrl_regs_i (
    .ap_clk, .ap_rst_n, .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
    .idle, .done, .reject_count, .issue_count,
    .reg_rvalid, .reg_rdata, .start_bit, .run_cycles, .chan_base
  );

  kvs_run_timer kvs_run_timer_i (
    .ap_clk, .ap_rst_n, .start_bit, .run_cycles, .idle, .done
  );

  mem_cmd_router #(.N_CHAN(N_CHAN)) mem_cmd_router_i (
    .ap_clk, .ap_rst_n, .cmd_valid, .cmd_write, .cmd_chan, .cmd_addr, .cmd_len,
    .idle, .chan_valid, .chan_write, .chan_addr, .chan_len, .reject_count
  );

  //////////////////////////////////////////////////////////////////////
  // one translator per memory channel
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    mem_chan_xlate mem_chan_xlate_i (
      .ap_clk      (ap_clk),
      .ap_rst_n    (ap_rst_n),
      .chan_valid  (chan_valid[i]),
      .chan_write  (chan_write),  // shared fields from the router
      .chan_addr   (chan_addr),
      .chan_len    (chan_len),
      .chan_base   (chan_base[i]),
      .mem_valid   (mem_valid[i]),
      .mem_write   (mem_write[i]),
      .mem_addr    (mem_addr[i*HOST_ADDR_W +: HOST_ADDR_W]),
      .mem_len     (mem_len[i*BURST_LEN_W +: BURST_LEN_W]),
      .issue_count (issue_count[i])
    );
  end

endmodule

`default_nettype wire

// ==== design/mem_chan_xlate.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_chan_xlate (
  input  wire                                     ap_clk,
  input  wire                                     ap_rst_n,
  input  wire                                     chan_valid,
  input  wire                                     chan_write,
  input  wire [kvs_mem_pkg::LOCAL_ADDR_W-1:0]     chan_addr,
  input  wire [kvs_mem_pkg::BURST_LEN_W-1:0]      chan_len,
  input  wire [kvs_mem_pkg::HOST_ADDR_W-1:0]      chan_base,
  output logic                                    mem_valid,
  output logic                                    mem_write,
  output logic [kvs_mem_pkg::HOST_ADDR_W-1:0]     mem_addr,
  output logic [kvs_mem_pkg::BURST_LEN_W-1:0]     mem_len,
  output logic [kvs_ctrl_pkg::CNT_W-1:0]          issue_count
);
  import kvs_mem_pkg::*;

  logic [HOST_ADDR_W-1:0] host_addr;

  // local offset zero extended, then moved into this channel's buffer
  assign host_addr = chan_base + HOST_ADDR_W'(chan_addr);

  //////////////////////////////////////////////////////////////////////
  // strobe and issue counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      mem_valid   <= 1'b0;
      issue_count <= '0;
    end else begin
      mem_valid <= chan_valid;
      if (chan_valid)
        issue_count <= issue_count + 1'b1;  // memory side never stalls
    end
  end

  // host command fields
  always_ff @(posedge ap_clk) begin
    if (chan_valid) begin
      mem_write <= chan_write;
      mem_addr  <= host_addr;
      mem_len   <= chan_len;
    end
  end

  a_quiet_after_reset: assert property (@(posedge ap_clk)
    !ap_rst_n |=> !mem_valid);

endmodule

`default_nettype wire

// ==== design/mem_cmd_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_cmd_router #(
  parameter int N_CHAN = 2
) (
  input  wire                                     ap_clk,
  input  wire                                     ap_rst_n,
  input  wire                                     cmd_valid,
  input  wire                                     cmd_write,
  input  wire [kvs_mem_pkg::CHAN_ID_W-1:0]        cmd_chan,
  input  wire [kvs_mem_pkg::LOCAL_ADDR_W-1:0]     cmd_addr,
  input  wire [kvs_mem_pkg::BURST_LEN_W-1:0]      cmd_len,
  input  wire                                     idle,
  output logic [N_CHAN-1:0]                       chan_valid,
  output logic                                    chan_write,
  output logic [kvs_mem_pkg::LOCAL_ADDR_W-1:0]    chan_addr,
  output logic [kvs_mem_pkg::BURST_LEN_W-1:0]     chan_len,
  output logic [kvs_ctrl_pkg::CNT_W-1:0]          reject_count
);
  import kvs_mem_pkg::*;

  // first channel number that does not exist
  localparam logic [CHAN_ID_W-1:0] CHAN_LIMIT = CHAN_ID_W'(N_CHAN);

  logic cmd_accept;

  // only during a run, and only to a real channel
  assign cmd_accept = cmd_valid & ~idle & (cmd_chan < CHAN_LIMIT);

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      chan_valid   <= '0;
      reject_count <= '0;
    end else begin
      for (int i = 0; i < N_CHAN; i++)
        chan_valid[i] <= cmd_accept && (cmd_chan == CHAN_ID_W'(i));
      if (cmd_valid && !cmd_accept)
        reject_count <= reject_count + 1'b1;
    end
  end

  // shared command fields, qualified by chan_valid
  always_ff @(posedge ap_clk) begin
    if (cmd_accept) begin
      chan_write <= cmd_write;
      chan_addr  <= cmd_addr;
      chan_len   <= cmd_len;
    end
  end

  a_chan_onehot: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    $onehot0(chan_valid));

endmodule

`default_nettype wire

// ==== design/kvs_run_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module kvs_run_timer (
  input  wire                                  ap_clk,
  input  wire                                  ap_rst_n,
  input  wire                                  start_bit,
  input  wire [kvs_ctrl_pkg::RUN_CNT_W-1:0]    run_cycles,
  output logic                                 idle,
  output logic                                 done
);
  import kvs_ctrl_pkg::*;

  logic                 start_q;
  logic                 start_pulse;
  logic                 busy;
  logic [RUN_CNT_W-1:0] count;  // busy cycles still to go

  assign start_pulse = start_bit & ~start_q;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_q <= 1'b0;
      busy    <= 1'b0;
      count   <= '0;
      done    <= 1'b0;
    end else begin
      start_q <= start_bit;
      done    <= 1'b0;
      if (start_pulse) begin
        // new start reloads even in the middle of a run
        count <= run_cycles;
        busy  <= (run_cycles != '0);
        done  <= (run_cycles == '0);  // zero length, straight to done
      end else if (busy) begin
        count <= count - 1'b1;
        if (count == RUN_CNT_W'(1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  assign idle = ~busy;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_done_when_idle: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    done |-> idle);

  a_done_single: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    done |=> !done);

endmodule

`default_nettype wire

// ==== design/kvs_ctrl_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module kvs_ctrl_regs #(
  parameter int N_CHAN = 2
) (
  input  wire                                                    ap_clk,
  input  wire                                                    ap_rst_n,
  input  wire                                                    reg_wr,
  input  wire                                                    reg_rd,
  input  wire [kvs_ctrl_pkg::REG_ADDR_W-1:0]                     reg_addr,
  input  wire [kvs_ctrl_pkg::REG_DATA_W-1:0]                     reg_wdata,
  input  wire                                                    idle,
  input  wire                                                    done,
  input  wire [kvs_ctrl_pkg::CNT_W-1:0]                          reject_count,
  input  wire [N_CHAN-1:0][kvs_ctrl_pkg::CNT_W-1:0]              issue_count,
  output logic                                                   reg_rvalid,
  output logic [kvs_ctrl_pkg::REG_DATA_W-1:0]                    reg_rdata,
  output logic                                                   start_bit,
  output logic [kvs_ctrl_pkg::RUN_CNT_W-1:0]                     run_cycles,
  output logic [N_CHAN-1:0][kvs_mem_pkg::HOST_ADDR_W-1:0]        chan_base
);
  import kvs_ctrl_pkg::*;
  import kvs_mem_pkg::*;

  logic                  done_sticky;
  logic [REG_DATA_W-1:0] rd_data;

  // address of one register inside channel block ch
  function automatic logic [REG_ADDR_W-1:0] chan_reg(input int ch, input int ofs);
    return REG_ADDR_W'(int'(ADDR_CHAN_BASE) + CHAN_STRIDE * ch + ofs);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_bit   <= 1'b0;
      done_sticky <= 1'b0;
      run_cycles  <= '0;
      chan_base   <= '0;
    end else begin
      if (reg_wr) begin
        case (reg_addr)
          ADDR_CTRL: begin
            start_bit   <= reg_wdata[0];
            done_sticky <= 1'b0;  // any ctrl write clears it
          end
          ADDR_RUN_LO: run_cycles[REG_DATA_W-1:0]         <= reg_wdata;
          ADDR_RUN_HI: run_cycles[RUN_CNT_W-1:REG_DATA_W] <= reg_wdata;
          default: ;
        endcase
        for (int i = 0; i < N_CHAN; i++) begin
          if (reg_addr == chan_reg(i, CHAN_OFS_BASE_LO))
            chan_base[i][REG_DATA_W-1:0] <= reg_wdata;
          if (reg_addr == chan_reg(i, CHAN_OFS_BASE_HI))
            chan_base[i][HOST_ADDR_W-1:REG_DATA_W] <= reg_wdata;
        end
      end
      // done pulse wins over a clear in the same cycle
      if (done)
        done_sticky <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;  // unmapped reads as zero
    case (reg_addr)
      ADDR_CTRL:   rd_data[0] = start_bit;
      ADDR_STATUS: rd_data    = {{(REG_DATA_W-2){1'b0}}, done_sticky, idle};
      ADDR_RUN_LO: rd_data    = run_cycles[REG_DATA_W-1:0];
      ADDR_RUN_HI: rd_data    = run_cycles[RUN_CNT_W-1:REG_DATA_W];
      ADDR_REJECT: rd_data    = reject_count;
      default: ;
    endcase
    for (int i = 0; i < N_CHAN; i++) begin
      if (reg_addr == chan_reg(i, CHAN_OFS_BASE_LO))
        rd_data = chan_base[i][REG_DATA_W-1:0];
      if (reg_addr == chan_reg(i, CHAN_OFS_BASE_HI))
        rd_data = chan_base[i][HOST_ADDR_W-1:REG_DATA_W];
      if (reg_addr == chan_reg(i, CHAN_OFS_COUNT))
        rd_data = issue_count[i];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n)
      reg_rvalid <= 1'b0;
    else
      reg_rvalid <= reg_rd;
  end

  always_ff @(posedge ap_clk) begin
    if (reg_rd)
      reg_rdata <= rd_data;  // answer one cycle after the strobe
  end

  // read answers only follow a read strobe
  a_rvalid_after_rd: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    reg_rvalid |-> $past(reg_rd));

endmodule

`default_nettype wire

// ==== design/kvs_mem_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////////////////////////
// memory command widths
//////////////////////////////////////////////////////////////////////

package kvs_mem_pkg;

  // engine side address, offset inside one channel's buffer
  localparam int LOCAL_ADDR_W = 34;

  // host side address after the base pointer is added
  localparam int HOST_ADDR_W = 64;

  localparam int BURST_LEN_W = 8;  // beats minus one, as on AXI

  // channel number carried by each engine command
  // wide enough for 16, only N_CHAN of them exist
  localparam int CHAN_ID_W = 4;

endpackage

`default_nettype wire

// ==== design/kvs_ctrl_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////////////////////////
// control side widths and register map
//////////////////////////////////////////////////////////////////////

package kvs_ctrl_pkg;

  // register port
  localparam int REG_ADDR_W = 8;
  localparam int REG_DATA_W = 32;

  localparam int RUN_CNT_W = 64;  // run length, in cycles
  localparam int CNT_W     = 32;  // issue and reject counters

  // fixed registers
  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL   = 8'h00;  // bit 0 start
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS = 8'h04;  // bit 0 idle, bit 1 sticky done
  localparam logic [REG_ADDR_W-1:0] ADDR_RUN_LO = 8'h08;
  localparam logic [REG_ADDR_W-1:0] ADDR_RUN_HI = 8'h0C;
  localparam logic [REG_ADDR_W-1:0] ADDR_REJECT = 8'h10;

  // per channel blocks start here, one block per channel
  localparam logic [REG_ADDR_W-1:0] ADDR_CHAN_BASE = 8'h20;
  localparam int CHAN_STRIDE = 16;

  // offsets inside one channel block
  localparam int CHAN_OFS_BASE_LO = 0;
  localparam int CHAN_OFS_BASE_HI = 4;
  localparam int CHAN_OFS_COUNT   = 8;

endpackage

`default_nettype wire
